/* hdl/spm_defs.svh */
// size macros for the banked scratchpad, included by every file that sizes the design.
`ifndef SPM_DEFS_SVH
`define SPM_DEFS_SVH

//////////////////////////////////////////////////
// memory geometry
//////////////////////////////////////////////////

// total word width in bits.
`define SPM_WIDTH 32

// total depth in words.
`define SPM_ELS 256

// width banks, must divide SPM_WIDTH.
`define SPM_NUM_WIDTH_BANK 2

// depth banks, must divide SPM_ELS.
`define SPM_NUM_DEPTH_BANK 4

//////////////////////////////////////////////////
// response path
//////////////////////////////////////////////////

`define SPM_RESP_DEPTH 2 // entries in the response fifo.

`endif

/* hdl/spm_pkg.sv */
// shared types of the scratchpad, imported by the modules that carry addresses or data.
`include "spm_defs.svh"

package spm_pkg;

  //////////////////////////////////////////////////
  // plain vector types
  //////////////////////////////////////////////////

  // word address over the whole store.
  typedef logic [$clog2(`SPM_ELS)-1:0] spm_addr_t;

  // one full data word, all width banks together.
  typedef logic [`SPM_WIDTH-1:0] spm_data_t;

  // index width of the depth banks, kept at one bit or more.
  localparam int SPM_BANK_IDX_W =
    ($clog2(`SPM_NUM_DEPTH_BANK) > 0) ? $clog2(`SPM_NUM_DEPTH_BANK) : 1;

  // depth bank select, taken from the low address bits.
  typedef logic [SPM_BANK_IDX_W-1:0] spm_bank_idx_t;

  //////////////////////////////////////////////////
  // request bundle
  //////////////////////////////////////////////////

  typedef struct packed {
    logic      we;    // write when set, read otherwise.
    spm_addr_t addr;  // word address.
    spm_data_t wdata; // write data, ignored on reads.
  } spm_req_t;

endpackage

/* hdl/spm_bank_ram.sv */
// one synchronous single-port bank, instantiated by the banked array for each bank slice.
module spm_bank_ram #(
  parameter int WIDTH = 16,
  parameter int ELS   = 64
) (
  input  logic                   clk_i,
  input  logic                   v_i,
  input  logic                   w_i,
  input  logic [$clog2(ELS)-1:0] addr_i,
  input  logic [WIDTH-1:0]       data_i,
  output logic [WIDTH-1:0]       data_o
);

  //////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////

  logic [WIDTH-1:0] mem [ELS]; // bank contents.

  // write port, stores the word on an enabled write.
  always_ff @(posedge clk_i) begin
    if (v_i && w_i) begin
      mem[addr_i] <= data_i;
    end
  end

  //////////////////////////////////////////////////
  // read port
  //////////////////////////////////////////////////

  // the output register only loads on an enabled read,
  // so data_o keeps the last read word across idle and write cycles.
  always_ff @(posedge clk_i) begin
    if (v_i && !w_i) begin
      data_o <= mem[addr_i];
    end
  end

endmodule

/* hdl/spm_banked_ram.sv */
// banked single-port array, splits the store into width and depth banks under one port.
`include "spm_defs.svh"

module spm_banked_ram
  import spm_pkg::*;
#(
  parameter int WIDTH          = `SPM_WIDTH,
  parameter int ELS            = `SPM_ELS,
  parameter int NUM_WIDTH_BANK = `SPM_NUM_WIDTH_BANK,
  parameter int NUM_DEPTH_BANK = `SPM_NUM_DEPTH_BANK
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      v_i,
  input  logic      w_i,
  input  spm_addr_t addr_i,
  input  spm_data_t data_i,
  output spm_data_t data_o
);

  localparam int BANK_WIDTH  = WIDTH / NUM_WIDTH_BANK;
  localparam int BANK_DEPTH  = ELS / NUM_DEPTH_BANK;
  localparam int BANK_ADDR_W = $clog2(BANK_DEPTH);

  //////////////////////////////////////////////////
  // elaboration checks
  //////////////////////////////////////////////////

  if (WIDTH % NUM_WIDTH_BANK != 0) begin : g_bad_width_split
    $error("width bank count does not divide the word width");
  end
  if (ELS % NUM_DEPTH_BANK != 0) begin : g_bad_depth_split
    $error("depth bank count does not divide the depth");
  end
  if ($bits(spm_data_t) != WIDTH || 2 ** $bits(spm_addr_t) != ELS) begin : g_bad_types
    $error("array size differs from the package types");
  end

  if (NUM_DEPTH_BANK == 1) begin : g_db1

    // single depth bank, the full address goes straight to each slice.
    for (genvar i = 0; i < NUM_WIDTH_BANK; i++) begin : g_wb
      spm_bank_ram #(
        .WIDTH (BANK_WIDTH),
        .ELS   (BANK_DEPTH)
      ) u_bank (
        .clk_i  (clk_i),
        .v_i    (v_i),
        .w_i    (w_i),
        .addr_i (addr_i),
        .data_i (data_i[i*BANK_WIDTH +: BANK_WIDTH]),
        .data_o (data_o[i*BANK_WIDTH +: BANK_WIDTH])
      );
    end

  end else begin : g_dbn

    localparam int IDX_W = $bits(spm_bank_idx_t);

    if (2 ** IDX_W != NUM_DEPTH_BANK) begin : g_bad_idx
      $error("depth bank count must match the bank index width");
    end

    spm_bank_idx_t                        depth_bank_idx;   // bank hit by this access.
    spm_bank_idx_t                        depth_bank_idx_r; // bank of the last read.
    logic [NUM_DEPTH_BANK-1:0]            bank_v;
    logic [BANK_ADDR_W-1:0]               bank_addr;
    spm_data_t [NUM_DEPTH_BANK-1:0]       bank_data;

    assign depth_bank_idx = addr_i[IDX_W-1:0];
    assign bank_addr      = addr_i[IDX_W +: BANK_ADDR_W];

    //////////////////////////////////////////////////
    // bank grid
    //////////////////////////////////////////////////

    for (genvar j = 0; j < NUM_DEPTH_BANK; j++) begin : g_db
      assign bank_v[j] = v_i && (depth_bank_idx == spm_bank_idx_t'(j)); // one hot enable.

      for (genvar i = 0; i < NUM_WIDTH_BANK; i++) begin : g_wb
        spm_bank_ram #(
          .WIDTH (BANK_WIDTH),
          .ELS   (BANK_DEPTH)
        ) u_bank (
          .clk_i  (clk_i),
          .v_i    (bank_v[j]),
          .w_i    (w_i),
          .addr_i (bank_addr),
          .data_i (data_i[i*BANK_WIDTH +: BANK_WIDTH]),
          .data_o (bank_data[j][i*BANK_WIDTH +: BANK_WIDTH])
        );
      end
    end

    // remember which bank was read, the data shows up one edge later.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        depth_bank_idx_r <= '0;
      end else if (v_i && !w_i) begin
        depth_bank_idx_r <= depth_bank_idx;
      end
    end

    assign data_o = bank_data[depth_bank_idx_r]; // output mux.

  end

endmodule

/* hdl/spm_req_ctrl.sv */
// request controller, turns accepted requests into array strobes and paces reads to buffer space.
`include "spm_defs.svh"

module spm_req_ctrl
  import spm_pkg::*;
(
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,

  // request port.
  input  logic                                    req_valid_i,
  input  spm_req_t                                req_i,
  output logic                                    req_ready_o,

  // array strobes.
  output logic                                    ram_v_o,
  output logic                                    ram_w_o,
  output spm_addr_t                               ram_addr_o,
  output spm_data_t                               ram_wdata_o,

  // response buffer side.
  input  logic [$clog2(`SPM_RESP_DEPTH + 1)-1:0]  free_i,
  output logic                                    push_o
);

  localparam int CNT_W = $clog2(`SPM_RESP_DEPTH + 1);

  logic req_fire;    // request handshake this cycle.
  logic read_fire;   // accepted request is a read.
  logic in_flight_r; // read issued last cycle, data at the array output now.

  //////////////////////////////////////////////////
  // acceptance
  //////////////////////////////////////////////////

  // a read in flight already owns one of the free slots,
  // so only the space beyond it may be handed out.
  assign req_ready_o = (free_i > CNT_W'(in_flight_r));

  assign req_fire  = req_valid_i && req_ready_o;
  assign read_fire = req_fire && !req_i.we;

  //////////////////////////////////////////////////
  // array strobes
  //////////////////////////////////////////////////

  assign ram_v_o     = req_fire;    // one access per handshake.
  assign ram_w_o     = req_i.we;
  assign ram_addr_o  = req_i.addr;
  assign ram_wdata_o = req_i.wdata;

  //////////////////////////////////////////////////
  // in-flight read tracking
  //////////////////////////////////////////////////

  // set for exactly the cycle after a read is accepted.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      in_flight_r <= 1'b0;
    end else begin
      in_flight_r <= read_fire;
    end
  end

  assign push_o = in_flight_r; // buffer captures the array data now.

endmodule

/* hdl/spm_resp_buffer.sv */
// response FIFO between the array and the response port, reports its free slots to the controller.
`include "spm_defs.svh"

module spm_resp_buffer
  import spm_pkg::*;
#(
  parameter int DEPTH = `SPM_RESP_DEPTH
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         push_i,
  input  spm_data_t                    data_i,
  output logic [$clog2(DEPTH + 1)-1:0] free_o,
  output logic                         valid_o,
  output spm_data_t                    data_o,
  input  logic                         ready_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;

  spm_data_t        mem [DEPTH]; // entry storage.
  ptr_t             wr_ptr_r;
  ptr_t             rd_ptr_r;
  logic [CNT_W-1:0] count_r;
  logic             pop;

  // wrap at DEPTH, which need not be a power of two.
  function automatic ptr_t ptr_inc(ptr_t p);
    return (p == ptr_t'(DEPTH - 1)) ? '0 : ptr_t'(p + 1'b1);
  endfunction

  assign pop = valid_o && ready_i;

  //////////////////////////////////////////////////
  // pointers and occupancy
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push_i) wr_ptr_r <= ptr_inc(wr_ptr_r);
      if (pop)    rd_ptr_r <= ptr_inc(rd_ptr_r);
      case ({push_i, pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r; // none, or push and pop together.
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr_r] <= data_i;
    end
  end

  assign valid_o = (count_r != '0);
  assign data_o  = mem[rd_ptr_r];         // head entry.
  assign free_o  = CNT_W'(DEPTH) - count_r;

endmodule

/* hdl/spm_top.sv */
// top of the scratchpad, the block the testbench instantiates and drives through its two ports.
`include "spm_defs.svh"

module spm_top
  import spm_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      req_valid_i,
  input  spm_req_t  req_i,
  output logic      req_ready_o,
  output logic      resp_valid_o,
  output spm_data_t resp_data_o,
  input  logic      resp_ready_i
);

  logic                                   ram_v;
  logic                                   ram_w;
  spm_addr_t                              ram_addr;
  spm_data_t                              ram_wdata;
  spm_data_t                              ram_rdata; // array read data into the fifo.
  logic                                   push;
  logic [$clog2(`SPM_RESP_DEPTH + 1)-1:0] free;

  //////////////////////////////////////////////////
  // request side
  //////////////////////////////////////////////////

  spm_req_ctrl u_req_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .req_ready_o (req_ready_o),
    .ram_v_o     (ram_v),
    .ram_w_o     (ram_w),
    .ram_addr_o  (ram_addr),
    .ram_wdata_o (ram_wdata),
    .free_i      (free),
    .push_o      (push)
  );

  spm_banked_ram #(
    .WIDTH          (`SPM_WIDTH),
    .ELS            (`SPM_ELS),
    .NUM_WIDTH_BANK (`SPM_NUM_WIDTH_BANK),
    .NUM_DEPTH_BANK (`SPM_NUM_DEPTH_BANK)
  ) u_banked_ram (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .v_i     (ram_v),
    .w_i     (ram_w),
    .addr_i  (ram_addr),
    .data_i  (ram_wdata),
    .data_o  (ram_rdata)
  );

  //////////////////////////////////////////////////
  // response side
  //////////////////////////////////////////////////

  spm_resp_buffer #(
    .DEPTH (`SPM_RESP_DEPTH)
  ) u_resp_buffer (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (push),
    .data_i  (ram_rdata),
    .free_o  (free),
    .valid_o (resp_valid_o),
    .data_o  (resp_data_o),
    .ready_i (resp_ready_i)
  );

endmodule

/* test/spm_sva.sv */
// handshake and occupancy checks on the scratchpad, bound into the top level by the bind below.
`include "spm_defs.svh"

module spm_sva
  import spm_pkg::*;
(
  input logic                                   clk_i,
  input logic                                   rst_n_i,
  input logic                                   req_ready_i,
  input logic                                   resp_valid_i,
  input spm_data_t                              resp_data_i,
  input logic                                   resp_ready_i,
  input logic                                   push_i,
  input logic [$clog2(`SPM_RESP_DEPTH + 1)-1:0] free_i
);

  int fail_count = 0; // failed assertions so far.

  // a response that is not taken keeps its valid and data.
  a_resp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable(resp_data_i))
    else begin
      fail_count++;
      $error("response valid or data changed before the response was taken");
    end

  // the controller never pushes into a full buffer.
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> free_i != '0)
    else begin
      fail_count++;
      $error("push into the response buffer while it had no free slot");
    end

  a_ready_after_reset: assert property (@(posedge clk_i) $rose(rst_n_i) |-> req_ready_i)
    else begin
      fail_count++;
      $error("request ready was low right after reset");
    end

endmodule

bind spm_top spm_sva u_sva (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .req_ready_i  (req_ready_o),
  .resp_valid_i (resp_valid_o),
  .resp_data_i  (resp_data_o),
  .resp_ready_i (resp_ready_i),
  .push_i       (push),
  .free_i       (free)
);

/* test/spm_tb.sv */
// directed testbench for the scratchpad top, elaborated as the simulation top from compile.f.
module spm_tb
  import spm_pkg::*;
();

  localparam int TIMEOUT       = 200;  // cycles to wait for request ready.
  localparam int DRAIN_TIMEOUT = 1000; // cycles to wait for all responses.

  typedef enum logic [1:0] {RESP_ALWAYS, RESP_HOLD, RESP_RANDOM} resp_mode_t;

  logic         clk = 1'b0;
  logic         rst_n;
  logic         req_valid;
  spm_req_t     req;
  logic         req_ready;
  logic         resp_valid;
  spm_data_t    resp_data;
  logic         resp_ready;

  spm_data_t    shadow [2 ** $bits(spm_addr_t)]; // last word written per address.
  spm_data_t    exp_q [$];                       // read data still owed, oldest first.
  resp_mode_t   resp_mode;
  logic [255:0] ready_pattern;                   // random response ready bits.
  logic [7:0]   pattern_idx;

  spm_top uut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .req_valid_i  (req_valid),
    .req_i        (req),
    .req_ready_o  (req_ready),
    .resp_valid_o (resp_valid),
    .resp_data_o  (resp_data),
    .resp_ready_i (resp_ready)
  );

  always #10 clk = ~clk;

  task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at the first error");
  endtask

  //////////////////////////////////////////////////
  // response side
  //////////////////////////////////////////////////

  // sets response ready for the coming edge, then takes the head if it is offered.
  always @(negedge clk) begin : collect
    spm_data_t expected;
    case (resp_mode)
      RESP_HOLD:   resp_ready = 1'b0;
      RESP_RANDOM: begin
        resp_ready  = ready_pattern[pattern_idx];
        pattern_idx = pattern_idx + 8'd1;
      end
      default:     resp_ready = 1'b1;
    endcase
    if (rst_n && resp_valid && resp_ready) begin
      if (exp_q.size() == 0) begin
        stop_with_error("a response arrived while no read was outstanding");
      end else begin
        expected = exp_q.pop_front();
        assert (resp_data === expected) else stop_with_error($sformatf(
          "CHECK FAILED t=%0t resp_data_o got %h expected %h", $time, resp_data, expected));
      end
    end
  end

  always @(negedge clk) begin : watch_sva
    if (uut.u_sva.fail_count != 0) begin
      stop_with_error("a handshake or occupancy assertion on the top level failed");
    end
  end

  //////////////////////////////////////////////////
  // request side
  //////////////////////////////////////////////////

  // called at a falling edge, returns at the falling edge after the handshake.
  task automatic send_req(input logic is_write, input spm_addr_t addr, input spm_data_t wdata);
    int waited;
    waited    = 0;
    req       = '{we: is_write, addr: addr, wdata: wdata};
    req_valid = 1'b1;
    while (!req_ready) begin
      if (waited >= TIMEOUT) begin
        stop_with_error("request was not accepted before the timeout");
      end else begin
        @(negedge clk);
        waited++;
      end
    end
    @(negedge clk); // handshake on the rising edge in between.
    req_valid = 1'b0;
  endtask

  task automatic do_write(input spm_addr_t addr, input spm_data_t data);
    send_req(1'b1, addr, data);
    shadow[addr] = data;
  endtask

  task automatic do_read(input spm_addr_t addr);
    send_req(1'b0, addr, '0);
    exp_q.push_back(shadow[addr]);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      if (waited >= DRAIN_TIMEOUT) begin
        stop_with_error("outstanding responses did not arrive before the timeout");
      end else begin
        @(negedge clk);
        waited++;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic check_reset_state();
    assert (resp_valid === 1'b0) else stop_with_error($sformatf(
      "CHECK FAILED t=%0t resp_valid_o got %b expected 0", $time, resp_valid));
    assert (req_ready === 1'b1) else stop_with_error($sformatf(
      "CHECK FAILED t=%0t req_ready_o got %b expected 1", $time, req_ready));
  endtask

  task automatic test_depth_banks();
    for (int i = 0; i < 8; i++) begin
      do_write(spm_addr_t'(i), {8'(i), 8'ha5, 8'(~i), 8'h3c}); // each bank twice.
    end
    for (int i = 0; i < 8; i++) begin
      do_read(spm_addr_t'(i));
    end
    wait_drain();
  endtask

  task automatic test_width_banks();
    do_write(8'h9c, 32'ha5a5_3c3c);
    do_write(8'h9c, 32'h1234_fedc); // both halves change.
    do_read(8'h9c);
    wait_drain();
  endtask

  task automatic test_pipelined_reads();
    for (int i = 7; i >= 0; i--) begin
      do_read(spm_addr_t'(i));
    end
    do_read(8'h9c);
    wait_drain();
  endtask

  task automatic test_back_pressure();
    resp_mode = RESP_HOLD;
    @(negedge clk);
    do_read(8'd3);
    do_read(8'd5);
    req       = '{we: 1'b0, addr: 8'd6, wdata: '0};
    req_valid = 1'b1;
    repeat (6) begin
      assert (req_ready === 1'b0) else stop_with_error($sformatf(
        "CHECK FAILED t=%0t req_ready_o got %b expected 0", $time, req_ready));
      assert (resp_valid === 1'b1) else stop_with_error($sformatf(
        "CHECK FAILED t=%0t resp_valid_o got %b expected 1", $time, resp_valid));
      @(negedge clk);
    end
    req_valid = 1'b0;
    assert (resp_data === exp_q[0]) else stop_with_error($sformatf(
      "CHECK FAILED t=%0t resp_data_o got %h expected %h", $time, resp_data, exp_q[0]));
    resp_mode = RESP_ALWAYS;
    do_read(8'd6);
    do_read(8'd1);
    do_read(8'd2);
    wait_drain();
  endtask

  task automatic test_random_mix();
    spm_addr_t addr;
    for (int i = 0; i < 2 ** $bits(spm_addr_t); i++) begin
      addr = spm_addr_t'(i);
      do_write(addr, {addr, ~addr, addr ^ 8'h5a, addr + 8'd1}); // fill every word.
    end
    for (int w = 0; w < 8; w++) begin
      ready_pattern[w*32 +: 32] = $urandom;
    end
    resp_mode = RESP_RANDOM;
    repeat (200) begin
      addr = spm_addr_t'($urandom_range(255, 0));
      if ($urandom_range(1, 0) == 1) begin
        do_write(addr, $urandom);
      end else begin
        do_read(addr);
      end
      if ($urandom_range(3, 0) == 0) begin
        @(negedge clk); // idle gap.
      end
    end
    resp_mode = RESP_ALWAYS;
    wait_drain();
  endtask

  initial begin : main
    void'($urandom(32'h52a7));
    rst_n         = 1'b0;
    req_valid     = 1'b0;
    req           = '0;
    resp_ready    = 1'b1;
    resp_mode     = RESP_ALWAYS;
    pattern_idx   = '0;
    ready_pattern = '0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_reset_state();
    test_depth_banks();
    test_width_banks();
    test_pipelined_reads();
    test_back_pressure();
    test_random_mix();
    if (uut.u_sva.fail_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+hdl
hdl/spm_pkg.sv
hdl/spm_bank_ram.sv
hdl/spm_banked_ram.sv
hdl/spm_req_ctrl.sv
hdl/spm_resp_buffer.sv
hdl/spm_top.sv
test/spm_sva.sv
test/spm_tb.sv
